// File: exe_consts.svh
//----------------------------------------------------------
// execution cluster constants
// widths, counts and the bit layout of the ALU sub-op field
//----------------------------------------------------------
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// datapath and cluster sizing
`define EXE_DATA_W 64
`define EXE_WORD_W 32
`define EXE_LANES 2
`define EXE_NREGS 32

// sub-op flag positions, meaning depends on the op
`define ALU_SUB_UNSIGNED 0
`define ALU_SUB_WORD 1
`define ALU_SUB_SUB 2
`define ALU_SUB_RIGHT 3
`define ALU_SUB_ARITH 4
`define ALU_SUB_CMP_LT 5
`define ALU_SUB_NEG 6

// two-bit logic selector, shares bits with the add/shift flags
`define ALU_SUB_LOGIC_LSB 0
`define ALU_LOGIC_AND 2'd0
`define ALU_LOGIC_OR 2'd1
`define ALU_LOGIC_XOR 2'd2

`endif

// File: alu_pkg.sv
//----------------------------------------------------------
// ALU types
// operation codes, operand widths and the command struct
//----------------------------------------------------------
`default_nettype none

`include "exe_consts.svh"

package alu_pkg;

	// operand and result
	typedef logic [`EXE_DATA_W-1:0] data_t;
	// low word of an operand
	typedef logic [`EXE_WORD_W-1:0] word_t;
	// shift amount for the full width
	typedef logic [$clog2(`EXE_DATA_W)-1:0] shamt_t;
	// per-op modifier flags
	typedef logic [7:0] sub_op_t;

	// no multiply slot
	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_COMP,
		ALU_SHIFT,
		ALU_LOGIC
	} alu_op_e;

	typedef struct packed {
		alu_op_e op;
		sub_op_t sub_op;
	} alu_command_t;

endpackage

`default_nettype wire

// File: exe_pkg.sv
//----------------------------------------------------------
// execution cluster types
// register and lane indices, issue and writeback packets
//----------------------------------------------------------
`default_nettype none

`include "exe_consts.svh"

package exe_pkg;
	import alu_pkg::*;

	typedef logic [$clog2(`EXE_NREGS)-1:0] reg_idx_t;
	typedef logic [$clog2(`EXE_LANES)-1:0] lane_idx_t;

	typedef struct packed {
		alu_command_t command;
		data_t data1;
		data_t data2;
		reg_idx_t rd;
	} issue_t;

	typedef struct packed {
		reg_idx_t rd;
		data_t data;
	} wb_t;

endpackage

`default_nettype wire

// File: issue_dispatch.sv
//----------------------------------------------------------
// issue dispatcher
// registers each issued op and hands it to the next lane
// in round-robin order, one strobe per op
//----------------------------------------------------------
`default_nettype none

`include "exe_consts.svh"

module issue_dispatch
	import exe_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  issue_valid,
	input  issue_t                issue,
	output logic [`EXE_LANES-1:0] lane_valid,
	output issue_t                lane_op [`EXE_LANES]
);

	localparam lane_idx_t LAST_LANE = lane_idx_t'(`EXE_LANES - 1);

	// lane that takes the next op
	lane_idx_t ptr;

	always_ff @(posedge clk) begin
		if (rst) begin
			ptr <= '0;
			lane_valid <= '0;
		end else begin
			lane_valid <= '0;
			if (issue_valid) begin
				lane_valid[ptr] <= 1'b1;
				if (ptr == LAST_LANE) begin
					ptr <= '0;
				end else begin
					ptr <= ptr + 1'b1;
				end
			end
		end
	end

	// packet stays put until this lane is picked again
	always_ff @(posedge clk) begin
		if (issue_valid) begin
			lane_op[ptr] <= issue;
		end
	end

endmodule

`default_nettype wire

// File: alu_exe.sv
//----------------------------------------------------------
// ALU core
// combinational add/sub, compare, shift and logic on one
// command and two operands
//----------------------------------------------------------
`default_nettype none

`include "exe_consts.svh"

module alu_exe
	import alu_pkg::*;
(
	input  alu_command_t command,
	input  data_t        data1,
	input  data_t        data2,
	output data_t        res
);

	localparam int SFT_W = $bits(shamt_t);
	localparam int WSFT_W = $clog2(`EXE_WORD_W);
	localparam int UPPER_W = `EXE_DATA_W - `EXE_WORD_W;

	logic op_word;
	logic op_neg;
	logic sft_right;
	logic sft_arith;
	logic sft_large;

	// per-function operands, zero unless that function is selected
	data_t add_a;
	data_t add_b;
	data_t cmp_a;
	data_t cmp_b;
	data_t sft_a;
	shamt_t sft_n;
	data_t logic_a;
	data_t logic_b;
	word_t sft_w;

	data_t res_add;
	logic res_cmp;
	word_t res_sft_w;
	data_t res_sft;
	data_t res_logic;

	assign op_word = command.sub_op[`ALU_SUB_WORD];
	assign op_neg = command.sub_op[`ALU_SUB_NEG];
	assign sft_right = command.sub_op[`ALU_SUB_RIGHT];
	assign sft_arith = command.sub_op[`ALU_SUB_ARITH];

	assign add_a = (command.op == ALU_ADD) ? data1 : '0;
	assign add_b = (command.op == ALU_ADD) ? data2 : '0;
	assign cmp_a = (command.op == ALU_COMP) ? data1 : '0;
	assign cmp_b = (command.op == ALU_COMP) ? data2 : '0;
	assign sft_a = (command.op == ALU_SHIFT) ? data1 : '0;
	assign sft_n = (command.op == ALU_SHIFT) ? data2[SFT_W-1:0] : '0;
	assign logic_a = (command.op == ALU_LOGIC) ? data1 : '0;
	assign logic_b = (command.op == ALU_LOGIC) ? data2 : '0;

	assign sft_w = sft_a[`EXE_WORD_W-1:0];

	// any bit above the legal amount range
	assign sft_large = op_word ? |data2[`EXE_DATA_W-1:WSFT_W] : |data2[`EXE_DATA_W-1:SFT_W];

	// add / subtract, overflow wraps
	assign res_add = command.sub_op[`ALU_SUB_SUB] ? add_a - add_b : add_a + add_b;

	always_comb begin
		if (command.sub_op[`ALU_SUB_CMP_LT]) begin
			if (command.sub_op[`ALU_SUB_UNSIGNED]) begin
				res_cmp = cmp_a < cmp_b;
			end else begin
				res_cmp = $signed(cmp_a) < $signed(cmp_b);
			end
		end else begin
			res_cmp = cmp_a == cmp_b;
		end
	end

	// word shifts only see the low word, sign is bit 31
	always_comb begin
		if (sft_large) begin
			res_sft_w = (sft_right && sft_arith) ? {`EXE_WORD_W{sft_w[`EXE_WORD_W-1]}} : '0;
		end else if (!sft_right) begin
			res_sft_w = sft_w << sft_n[WSFT_W-1:0];
		end else if (sft_arith) begin
			res_sft_w = $signed(sft_w) >>> sft_n[WSFT_W-1:0];
		end else begin
			res_sft_w = sft_w >> sft_n[WSFT_W-1:0];
		end
	end

	always_comb begin
		if (op_word) begin
			res_sft = {{UPPER_W{1'b0}}, res_sft_w};
		end else if (sft_large) begin
			res_sft = (sft_right && sft_arith) ? {`EXE_DATA_W{sft_a[`EXE_DATA_W-1]}} : '0;
		end else if (!sft_right) begin
			res_sft = sft_a << sft_n;
		end else if (sft_arith) begin
			res_sft = $signed(sft_a) >>> sft_n;
		end else begin
			res_sft = sft_a >> sft_n;
		end
	end

	always_comb begin
		case (command.sub_op[`ALU_SUB_LOGIC_LSB +: 2])
			`ALU_LOGIC_AND: res_logic = logic_a & logic_b;
			`ALU_LOGIC_OR: res_logic = logic_a | logic_b;
			`ALU_LOGIC_XOR: res_logic = logic_a ^ logic_b;
			default: res_logic = '0;
		endcase
	end

	// result select, negate applies to compare and logic
	always_comb begin
		case (command.op)
			ALU_ADD: begin
				res = op_word ? {{UPPER_W{1'b0}}, res_add[`EXE_WORD_W-1:0]} : res_add;
			end
			ALU_COMP: res = {{(`EXE_DATA_W-1){1'b0}}, res_cmp ^ op_neg};
			ALU_SHIFT: res = res_sft;
			ALU_LOGIC: res = op_neg ? ~res_logic : res_logic;
			default: res = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: alu_lane.sv
//----------------------------------------------------------
// ALU execution lane
// runs the ALU core on its dispatched op and registers the
// result tagged with the destination register
//----------------------------------------------------------
`default_nettype none

`include "exe_consts.svh"

module alu_lane
	import alu_pkg::*, exe_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   lane_valid,
	input  issue_t lane_op,
	output logic   res_valid,
	output wb_t    res
);

	data_t alu_res;

	// op is already held in the dispatcher register
	alu_exe u_alu_exe (
		.command(lane_op.command),
		.data1  (lane_op.data1),
		.data2  (lane_op.data2),
		.res    (alu_res)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= lane_valid;
		end
	end

	// result payload, tagged with rd
	always_ff @(posedge clk) begin
		if (lane_valid) begin
			res.rd <= lane_op.rd;
			res.data <= alu_res;
		end
	end

endmodule

`default_nettype wire

// File: result_collect.sv
//----------------------------------------------------------
// result collector
// merges lane results into one writeback strobe and holds
// the register file with its combinational read port
//----------------------------------------------------------
`default_nettype none

`include "exe_consts.svh"

module result_collect
	import alu_pkg::*, exe_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`EXE_LANES-1:0] res_valid,
	input  wb_t                   res [`EXE_LANES],
	output logic                  wb_valid,
	output wb_t                   wb,
	input  reg_idx_t              rd_addr,
	output data_t                 rd_data
);

	logic any_valid;
	wb_t sel_res;
	data_t regs [`EXE_NREGS];

	assign any_valid = |res_valid;

	// at most one lane finishes per cycle
	always_comb begin
		sel_res = '0;
		for (int i = 0; i < `EXE_LANES; i++) begin
			if (res_valid[i]) begin
				sel_res = res[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= any_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (any_valid) begin
			wb <= sel_res;
		end
	end

	// x0 is never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `EXE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

// File: exe_cluster.sv
//----------------------------------------------------------
// integer execution cluster
// dispatcher, round-robin ALU lanes and writeback collector
//----------------------------------------------------------
`default_nettype none

`include "exe_consts.svh"

module exe_cluster
	import alu_pkg::*, exe_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     issue_valid,
	input  issue_t   issue,
	output logic     wb_valid,
	output wb_t      wb,
	input  reg_idx_t rd_addr,
	output data_t    rd_data
);

	logic [`EXE_LANES-1:0] lane_valid;
	issue_t lane_op [`EXE_LANES];
	logic [`EXE_LANES-1:0] res_valid;
	wb_t res [`EXE_LANES];

	issue_dispatch u_dispatch (
		.clk        (clk),
		.rst        (rst),
		.issue_valid(issue_valid),
		.issue      (issue),
		.lane_valid (lane_valid),
		.lane_op    (lane_op)
	);

	for (genvar i = 0; i < `EXE_LANES; i++) begin : lanes_g
		alu_lane u_lane (
			.clk       (clk),
			.rst       (rst),
			.lane_valid(lane_valid[i]),
			.lane_op   (lane_op[i]),
			.res_valid (res_valid[i]),
			.res       (res[i])
		);
	end

	result_collect u_collect (
		.clk      (clk),
		.rst      (rst),
		.res_valid(res_valid),
		.res      (res),
		.wb_valid (wb_valid),
		.wb       (wb),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

endmodule

`default_nettype wire

// File: exe_cluster_props.sv
//----------------------------------------------------------
// execution cluster properties
// strobe latency, lane exclusivity and reset state
//----------------------------------------------------------
`default_nettype none

`include "exe_consts.svh"

module exe_cluster_props (
	input logic                  clk,
	input logic                  rst,
	input logic                  issue_valid,
	input logic [`EXE_LANES-1:0] res_valid,
	input logic                  wb_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	// every issue comes back exactly three cycles later
	wb_latency_a: assert property (@(posedge clk) disable iff (rst)
		wb_valid == $past(issue_valid, 3))
		else $error("wb_valid does not follow issue_valid by 3 cycles");

	// lanes finish in different cycles
	lane_excl_a: assert property (@(posedge clk) disable iff (rst)
		$onehot0(res_valid))
		else $error("more than one lane result valid in one cycle");

	wb_reset_a: assert property (@(posedge clk) $fell(rst) |-> !wb_valid)
		else $error("wb_valid high right after reset");

endmodule

bind exe_cluster exe_cluster_props u_props (
	.clk        (clk),
	.rst        (rst),
	.issue_valid(issue_valid),
	.res_valid  (res_valid),
	.wb_valid   (wb_valid)
);

`default_nettype wire

// File: exe_cluster_tb.sv
//----------------------------------------------------------
// execution cluster testbench
// issues ALU ops from the stimulus file with random gaps,
// checks every writeback and reads back the register file
//----------------------------------------------------------
`default_nettype none

`include "exe_consts.svh"

module exe_cluster_tb
	import alu_pkg::*, exe_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// one stimulus line, op plus expected result
	typedef struct packed {
		issue_t op;
		data_t result;
	} stim_t;

	// expected writeback and the cycle it must appear in
	typedef struct packed {
		wb_t wb;
		logic [31:0] cycle;
	} exp_wb_t;

	logic clk;
	logic rst;
	logic issue_valid;
	issue_t issue;
	logic wb_valid;
	wb_t wb;
	reg_idx_t rd_addr;
	data_t rd_data;

	stim_t stim_q [$];
	exp_wb_t exp_q [$];
	data_t shadow [`EXE_NREGS];
	int unsigned cycle = 0;
	int unsigned timeout_cycles = 64;

	exe_cluster dut (
		.clk        (clk),
		.rst        (rst),
		.issue_valid(issue_valid),
		.issue      (issue),
		.wb_valid   (wb_valid),
		.wb         (wb),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input data_t exp, input data_t got);
		$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, got);
		abort_run();
	endtask

	task automatic load_stimulus();
		int fd;
		int n;
		string line;
		logic [1:0] op;
		sub_op_t sub;
		data_t d1;
		data_t d2;
		data_t result;
		reg_idx_t rd;
		stim_t s;
		fd = $fopen("exe_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open exe_stimulus.txt");
			abort_run();
		end
		while ($fgets(line, fd) != 0) begin
			// skip comments and blank lines
			if (line.len() == 0 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h", op, sub, d1, d2, rd, result);
			if (n == 6) begin
				s.op.command.op = alu_op_e'(op);
				s.op.command.sub_op = sub;
				s.op.data1 = d1;
				s.op.data2 = d2;
				s.op.rd = rd;
				s.result = result;
				stim_q.push_back(s);
			end
		end
		$fclose(fd);
		if (stim_q.size() == 0) begin
			$display("stimulus file holds no operations");
			abort_run();
		end
	endtask

	task automatic check_registers();
		for (int r = 0; r < `EXE_NREGS; r++) begin
			@(posedge clk);
			#1;
			rd_addr = reg_idx_t'(r);
			@(negedge clk);
			assert (rd_data == shadow[r])
				else report_mismatch($sformatf("rd_data x%0d", r), shadow[r], rd_data);
		end
	endtask

	// writeback checker, outputs are settled at the falling edge
	always @(negedge clk) begin
		exp_wb_t e;
		if (!rst && wb_valid) begin
			assert (exp_q.size() != 0) else begin
				$display("writeback seen with no operation outstanding");
				abort_run();
			end
			e = exp_q.pop_front();
			assert (wb.rd == e.wb.rd)
				else report_mismatch("wb.rd", data_t'(e.wb.rd), data_t'(wb.rd));
			assert (wb.data == e.wb.data)
				else report_mismatch("wb.data", e.wb.data, wb.data);
			assert (cycle == e.cycle)
				else report_mismatch("wb_valid cycle", data_t'(e.cycle), data_t'(cycle));
		end
	end

	always @(negedge clk) begin
		if (cycle >= timeout_cycles) begin
			$display("timeout: writebacks missing");
			abort_run();
		end
	end

	initial begin
		integer seed;
		int gap;
		exp_wb_t e;
		seed = 32'h1946;
		rst = 1'b1;
		issue_valid = 1'b0;
		issue = '0;
		rd_addr = '0;
		foreach (shadow[i]) begin
			shadow[i] = '0;
		end
		load_stimulus();
		// up to three cycles per op, plus read-back and margin
		timeout_cycles = 3 * stim_q.size() + 64;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		foreach (stim_q[i]) begin
			@(posedge clk);
			#1;
			issue_valid = 1'b1;
			issue = stim_q[i].op;
			e.wb.rd = stim_q[i].op.rd;
			e.wb.data = stim_q[i].result;
			e.cycle = cycle + 3;
			exp_q.push_back(e);
			// x0 keeps reading zero
			if (stim_q[i].op.rd != '0) begin
				shadow[stim_q[i].op.rd] = stim_q[i].result;
			end
			gap = $unsigned($random(seed)) % 3;
			repeat (gap) begin
				@(posedge clk);
				#1;
				issue_valid = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		issue_valid = 1'b0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		check_registers();
		repeat (4) @(posedge clk);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: exe_stimulus.txt
# columns: op sub-op data1 data2 rd expected, all hex
# op codes: 0 add, 1 compare, 2 shift, 3 logic
0 00 7fffffffffffffff 0000000000000001 01 8000000000000000
0 04 0000000000000005 0000000000000007 02 fffffffffffffffe
0 02 123456787fffffff 0000000000000001 03 0000000080000000
0 06 0000000000000000 0000000000000001 04 00000000ffffffff
1 00 00000000deadbeef 00000000deadbeef 05 0000000000000001
1 40 00000000deadbeef 00000000deadbeef 06 0000000000000000
1 20 ffffffffffffffff 0000000000000001 07 0000000000000001
1 21 ffffffffffffffff 0000000000000001 08 0000000000000000
1 61 ffffffffffffffff 0000000000000001 09 0000000000000001
2 00 0000000000000001 000000000000003f 0a 8000000000000000
2 08 8000000000000000 0000000000000004 0b 0800000000000000
2 18 8000000000000000 0000000000000004 0c f800000000000000
2 18 8000000000000000 0000000000000040 0d ffffffffffffffff
2 02 ffffffff00000003 0000000000000004 0e 0000000000000030
2 1a 0000000080000000 0000000000000004 0f 00000000f8000000
2 0a 00000000ffffffff 0000000000000020 10 0000000000000000
2 1a 0000000080000000 0000000000000020 11 00000000ffffffff
3 00 ff00ff00ff00ff00 0ff00ff00ff00ff0 12 0f000f000f000f00
3 01 ff00ff00ff00ff00 0ff00ff00ff00ff0 13 fff0fff0fff0fff0
3 02 ff00ff00ff00ff00 0ff00ff00ff00ff0 14 f0f0f0f0f0f0f0f0
3 40 ff00ff00ff00ff00 0ff00ff00ff00ff0 15 f0fff0fff0fff0ff
3 42 ff00ff00ff00ff00 0ff00ff00ff00ff0 16 0f0f0f0f0f0f0f0f
0 00 0000000000000001 0000000000000002 00 0000000000000003
0 00 0000000000000010 0000000000000020 01 0000000000000030

// File: sim.f
+incdir+.
alu_pkg.sv
exe_pkg.sv
issue_dispatch.sv
alu_exe.sv
alu_lane.sv
result_collect.sv
exe_cluster.sv
exe_cluster_props.sv
exe_cluster_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the execution cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f sim.f --top-module exe_cluster_tb -o exe_sim
./obj_dir/exe_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
	echo "simulation ok"
else
	echo "simulation reported a failure"
	exit 1
fi
